//--- hdc_bundler.f
+incdir+design
design/hdc_hv_pkg.sv
design/hdc_ctrl_pkg.sv
design/hv_store_if.sv
design/hv_loader.sv
design/dim_counter.sv
design/counter_bank.sv
design/hv_readout.sv
design/hdc_bundler.sv
verification/hdc_bundler_properties.sv
verification/tb_hdc_bundler.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal --top-module tb_hdc_bundler \
    -f hdc_bundler.f -o tb_hdc_bundler > build.log 2>&1 \
    && ./obj_dir/tb_hdc_bundler +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- verification/tb_hdc_bundler.sv
`include "hdc_macros.svh"

module tb_hdc_bundler;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk, rst, in_valid, in_ctrl, rd_en, rd_valid;
    hdc_ctrl_pkg::in_word_u in_word;
    hdc_hv_pkg::chunk_idx_t rd_idx;
    hdc_hv_pkg::chunk_t     rd_data;
    hdc_hv_pkg::vec_count_t vec_count;

    // model keeps one signed vote count per dimension
    int          model_cnt [`HDC_DIM];
    int          model_idx = 0;
    logic [31:0] lcg_state = 32'h7569_07e6;
    int          errors = 0;
    int          tests = 0;

    hdc_bundler uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic hdc_ctrl_pkg::in_word_u ctrl_word(hdc_ctrl_pkg::ctrl_op_e op, int idx);
        hdc_ctrl_pkg::in_word_u w;
        w          = '0;
        w.ctrl.op  = op;
        w.ctrl.idx = hdc_hv_pkg::chunk_idx_t'(idx);
        return w;
    endfunction

    // one word for one cycle while the model follows along
    task automatic put_word(logic ctrl, hdc_ctrl_pkg::in_word_u w);
        in_valid = 1'b1;
        in_ctrl  = ctrl;
        in_word  = w;
        if (!ctrl) begin
            // a 1 bit votes down, a 0 bit votes up
            for (int j = 0; j < `HDC_CHUNK; j++) begin
                model_cnt[model_idx*`HDC_CHUNK + j] += w.data[j] ? -1 : 1;
            end
            model_idx = (model_idx + 1) % `HDC_CHUNKS;
        end else if (w.ctrl.op == hdc_ctrl_pkg::op_clear) begin
            model_cnt = '{default: 0};
            model_idx = 0;
        end else if (w.ctrl.op == hdc_ctrl_pkg::op_set_idx) begin
            model_idx = w.ctrl.idx;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_ctrl  = 1'b0;
    endtask

    task automatic check_chunk(string what, hdc_hv_pkg::chunk_t got, hdc_hv_pkg::chunk_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string what, hdc_hv_pkg::vec_count_t got,
                               hdc_hv_pkg::vec_count_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // read all chunks and the count, then one line for the test
    task automatic check_all(string name, int exp_vecs);
        hdc_hv_pkg::chunk_t exp;
        int e0;
        int waited;
        e0 = errors;
        // idle so the two-stage update path drains
        repeat (4) @(posedge clk);
        #1;
        for (int c = 0; c < `HDC_CHUNKS; c++) begin
            // bundled bit is set where the vote count went negative
            for (int j = 0; j < `HDC_CHUNK; j++) begin
                exp[j] = model_cnt[c*`HDC_CHUNK + j] < 0;
            end
            rd_en  = 1'b1;
            rd_idx = hdc_hv_pkg::chunk_idx_t'(c);
            @(posedge clk);
            #1;
            rd_en  = 1'b0;
            waited = 0;
            while (!rd_valid && waited < 16) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!rd_valid) begin
                $display("%s: rd_valid never came for chunk %0d within 16 cycles", name, c);
                errors++;
            end
            check_chunk($sformatf("%s chunk %0d", name, c), rd_data, exp);
        end
        check_count({name, " vec_count"}, vec_count, hdc_hv_pkg::vec_count_t'(exp_vecs));
        tests++;
        if (errors == e0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
        end
    endtask

    task automatic test_reset_state();
        check_all("reset_state", 0);
    endtask

    task automatic test_single_vector();
        repeat (`HDC_CHUNKS) put_word(1'b0, next_rand());
        check_all("single_vector", 1);
    endtask

    task automatic test_odd_majority();
        put_word(1'b1, ctrl_word(hdc_ctrl_pkg::op_clear, 0));
        repeat (7 * `HDC_CHUNKS) put_word(1'b0, next_rand());
        check_all("odd_majority", 7);
    endtask

    task automatic test_tie();
        hdc_hv_pkg::chunk_t v [`HDC_CHUNKS];
        put_word(1'b1, ctrl_word(hdc_ctrl_pkg::op_clear, 0));
        for (int c = 0; c < `HDC_CHUNKS; c++) begin
            v[c] = next_rand();
            put_word(1'b0, v[c]);
        end
        // complement cancels every vote so ties read 0
        for (int c = 0; c < `HDC_CHUNKS; c++) begin
            put_word(1'b0, ~v[c]);
        end
        check_all("tie", 2);
    endtask

    task automatic test_clear_set_idx();
        // partial vector that the clear drops
        repeat (3) put_word(1'b0, next_rand());
        put_word(1'b1, ctrl_word(hdc_ctrl_pkg::op_clear, 0));
        put_word(1'b1, ctrl_word(hdc_ctrl_pkg::op_set_idx, 5));
        // chunks 5, 6, 7 then the wrap closes one vector
        repeat (3) put_word(1'b0, next_rand());
        check_all("clear_set_idx", 1);
    endtask

    task automatic test_stream();
        put_word(1'b1, ctrl_word(hdc_ctrl_pkg::op_clear, 0));
        // no gaps so several chunks are in flight at once
        repeat (3 * `HDC_CHUNKS) put_word(1'b0, next_rand());
        check_all("stream", 3);
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_ctrl   = 1'b0;
        in_word   = '0;
        rd_en     = 1'b0;
        rd_idx    = '0;
        model_cnt = '{default: 0};
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_single_vector();
        test_odd_majority();
        test_tie();
        test_clear_set_idx();
        test_stream();
        $display("%0d tests, %0d errors, %0d assertion failures", tests, errors,
                 uut.u_props.fail_count);
        if (errors == 0 && uut.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verification/hdc_bundler_properties.sv
module hdc_bundler_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   in_valid,
    input logic                   in_ctrl,
    input hdc_ctrl_pkg::in_word_u in_word,
    input logic                   rd_en,
    input logic                   rd_valid,
    input hdc_hv_pkg::vec_count_t vec_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertion tally
    int   fail_count = 0;
    logic clear_word;

    // clear op accepted at the input port
    assign clear_word = in_valid && in_ctrl && (in_word.ctrl.op == hdc_ctrl_pkg::op_clear);

    // valid exactly one cycle after each read strobe
    rd_one_cycle: assert property (@(posedge clk) disable iff (rst) rd_valid == $past(rd_en))
        else begin
            $error("rd_valid does not follow rd_en by one cycle");
            fail_count++;
        end

    // no stretched valid without a new strobe
    rd_no_repeat: assert property (@(posedge clk) disable iff (rst)
        rd_valid && !rd_en |=> !rd_valid)
        else begin
            $error("rd_valid high two cycles without rd_en");
            fail_count++;
        end

    rd_low_in_rst: assert property (@(posedge clk) rst |=> !rd_valid)
        else begin
            $error("rd_valid high during reset");
            fail_count++;
        end

    // count already zero when sampled at the third edge after the clear word
    clear_zeroes: assert property (@(posedge clk) disable iff (rst)
        $past(clear_word, 3) |-> vec_count == '0)
        else begin
            $error("vec_count not zero after clear");
            fail_count++;
        end

endmodule

bind hdc_bundler hdc_bundler_properties u_props (.*);

//--- design/hdc_bundler.sv
`default_nettype none

module hdc_bundler (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // input word stream
    input  wire logic                    in_valid,
    input  wire logic                    in_ctrl,
    input  wire hdc_ctrl_pkg::in_word_u  in_word,
    // chunk readout
    input  wire logic                    rd_en,
    input  wire hdc_hv_pkg::chunk_idx_t  rd_idx,
    output wire logic                    rd_valid,
    output wire hdc_hv_pkg::chunk_t      rd_data,
    // vectors bundled since last clear
    output wire hdc_hv_pkg::vec_count_t  vec_count
);

    // loader to bank strobes
    hv_store_if st_if ();

    // bundled bits, one per dimension
    hdc_hv_pkg::hv_t sign_vec;

    // word decode and chunk sequencing
    hv_loader u_loader (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ctrl  (in_ctrl),
        .in_word  (in_word),
        .st       (st_if.loader)
    );

    // per-dimension vote counters
    counter_bank u_bank (
        .clk       (clk),
        .rst       (rst),
        .st        (st_if.bank),
        .sign_vec  (sign_vec),
        .vec_count (vec_count)
    );

    // registered chunk read
    hv_readout u_readout (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .sign_vec (sign_vec),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

//--- design/hv_readout.sv
`default_nettype none

`include "hdc_macros.svh"

module hv_readout (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rd_en,
    input  wire hdc_hv_pkg::chunk_idx_t rd_idx,
    input  wire hdc_hv_pkg::hv_t        sign_vec,
    output logic                        rd_valid,
    output hdc_hv_pkg::chunk_t          rd_data
);

    // addressed chunk of the live sign vector
    hdc_hv_pkg::chunk_t rd_sel;

    assign rd_sel = sign_vec[rd_idx*`HDC_CHUNK +: `HDC_CHUNK];

    // one-cycle valid per read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_sel;
        end
    end

endmodule

`default_nettype wire

//--- design/counter_bank.sv
`default_nettype none

`include "hdc_macros.svh"

module counter_bank (
    input  wire logic                  clk,
    input  wire logic                  rst,
    hv_store_if.bank                   st,
    output wire hdc_hv_pkg::hv_t       sign_vec,
    output hdc_hv_pkg::vec_count_t     vec_count
);

    // vec_done and clear delayed to match the counters' selection stage
    logic vec_done_q;
    logic clear_q;

    genvar c, j;
    generate
        for (c = 0; c < `HDC_CHUNKS; c++) begin : g_chunk
            // only the addressed chunk sees the strobe
            logic chunk_store;

            assign chunk_store = st.store && (st.idx == hdc_hv_pkg::chunk_idx_t'(c));

            for (j = 0; j < `HDC_CHUNK; j++) begin : g_dim
                dim_counter #(
                    .W (`HDC_CNT_W)
                ) u_dim (
                    .clk      (clk),
                    .rst      (rst),
                    .clear    (st.clear),
                    .store    (chunk_store),
                    .core_bit (st.bits[j]),
                    .sign_bit (sign_vec[c*`HDC_CHUNK + j])
                );
            end
        end
    endgenerate

    // completed vectors, same two-stage timing as the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            vec_done_q <= 1'b0;
            clear_q    <= 1'b0;
            vec_count  <= '0;
        end else begin
            vec_done_q <= st.vec_done;
            clear_q    <= st.clear;
            if (clear_q) begin
                vec_count <= '0;
            end else if (vec_done_q) begin
                vec_count <= vec_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dim_counter.sv
`default_nettype none

module dim_counter #(
    parameter int W = 12
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic clear,
    input  wire logic store,
    input  wire logic core_bit,
    output wire logic sign_bit
);

    // vote for this cycle: +1, -1 or 0
    logic signed [1:0]   sel;
    // clear lined up with the selection stage
    logic                clear_q;
    // running vote sum
    logic signed [W-1:0] acc;

    // selection stage
    // a 1 bit votes down, a 0 bit votes up
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sel <= 2'sd0;
        end else if (store) begin
            sel <= core_bit ? -2'sd1 : 2'sd1;
        end else begin
            sel <= 2'sd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= clear;
        end
    end

    // accumulate stage, no saturation
    always_ff @(posedge clk) begin
        if (rst || clear_q) begin
            acc <= '0;
        end else begin
            acc <= acc + {{(W-2){sel[1]}}, sel};
        end
    end

    // negative sum means ones won
    assign sign_bit = acc[W-1];

endmodule

`default_nettype wire

//--- design/hv_loader.sv
`default_nettype none

`include "hdc_macros.svh"

module hv_loader (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire logic                 in_ctrl,
    input  wire hdc_ctrl_pkg::in_word_u in_word,
    hv_store_if.loader                st
);

    // next chunk a data word lands in
    hdc_hv_pkg::chunk_idx_t idx_r;

    // word kind, qualified by valid
    logic is_data;
    logic is_ctrl;

    assign is_data = in_valid && !in_ctrl;
    assign is_ctrl = in_valid && in_ctrl;

    // strobes and the chunk index
    always_ff @(posedge clk) begin
        if (rst) begin
            idx_r       <= '0;
            st.store    <= 1'b0;
            st.clear    <= 1'b0;
            st.vec_done <= 1'b0;
        end else begin
            // pulses by default
            st.store    <= 1'b0;
            st.clear    <= 1'b0;
            st.vec_done <= 1'b0;
            if (is_data) begin
                st.store    <= 1'b1;
                // wrap 7 -> 0 closes a vector
                st.vec_done <= (idx_r == hdc_hv_pkg::chunk_idx_t'(`HDC_CHUNKS - 1));
                idx_r       <= idx_r + 1'b1;
            end else if (is_ctrl) begin
                case (in_word.ctrl.op)
                    hdc_ctrl_pkg::op_clear: begin
                        st.clear <= 1'b1;
                        idx_r    <= '0;
                    end
                    hdc_ctrl_pkg::op_set_idx: begin
                        // takes effect for the next data word
                        idx_r <= in_word.ctrl.idx;
                    end
                    default: begin
                        // nop, nothing to do
                    end
                endcase
            end
        end
    end

    // chunk payload
    // only looked at while store is high
    always_ff @(posedge clk) begin
        if (is_data) begin
            st.bits <= in_word.data;
            st.idx  <= idx_r;
        end
    end

endmodule

`default_nettype wire

//--- design/hv_store_if.sv
// loader to counter bank link
// every signal is registered on the loader side
interface hv_store_if;

    // chunk write strobe, one cycle per data word
    logic                   store;
    // chunk the strobe addresses
    hdc_hv_pkg::chunk_idx_t idx;
    // dimension bits for that chunk
    hdc_hv_pkg::chunk_t     bits;
    // zero all counters and the vector count
    logic                   clear;
    // last chunk of a vector, rides along with store
    logic                   vec_done;

    modport loader (
        output store, idx, bits, clear, vec_done
    );

    modport bank (
        input store, idx, bits, clear, vec_done
    );

endinterface

//--- design/hdc_ctrl_pkg.sv
`include "hdc_macros.svh"

package hdc_ctrl_pkg;

    // control operations carried in the top bits of a control word
    typedef enum logic [1:0] {
        op_nop     = 2'd0,
        op_clear   = 2'd1,
        op_set_idx = 2'd2
    } ctrl_op_e;

    // control word layout, msb first
    // op in [31:30], index in [29:27], rest unused
    typedef struct packed {
        ctrl_op_e                              op;
        hdc_hv_pkg::chunk_idx_t                idx;
        logic [`HDC_CHUNK-`HDC_IDX_W-3:0]      rsvd;
    } ctrl_word_t;

    // one input word, two readings
    // in_ctrl low -> data chunk
    // in_ctrl high -> control word
    typedef union packed {
        hdc_hv_pkg::chunk_t data;
        ctrl_word_t         ctrl;
    } in_word_u;

endpackage

//--- design/hdc_hv_pkg.sv
`include "hdc_macros.svh"

package hdc_hv_pkg;

    // one chunk of dimension bits, bit j is dimension (idx * HDC_CHUNK + j)
    typedef logic [`HDC_CHUNK-1:0] chunk_t;

    // full hypervector
    // chunk c sits in bits [c*HDC_CHUNK +: HDC_CHUNK]
    typedef logic [`HDC_DIM-1:0] hv_t;

    // selects one chunk of a hypervector
    typedef logic [`HDC_IDX_W-1:0] chunk_idx_t;

    // completed vectors since the last clear
    // wraps silently past 65535
    typedef logic [15:0] vec_count_t;

endpackage

//--- design/hdc_macros.svh
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// hypervector geometry
// number of dimensions in one hypervector
`define HDC_DIM 256

// one input word carries this many dimensions
`define HDC_CHUNK 32

// chunks per hypervector, HDC_DIM / HDC_CHUNK
`define HDC_CHUNKS 8

// width of the chunk index, log2 of HDC_CHUNKS
`define HDC_IDX_W 3

// per-dimension counter width, signed
// 12 bits holds up to 2047 votes either way
`define HDC_CNT_W 12

`endif
